// ==== Bender.yml ====
package:
  name: rv64_core

export_include_dirs:
  - .

sources:
  # Design, in compile order
  - files:
      - rv64_core_pkg.sv
      - rv64_frontend.sv
      - rv64_regfile.sv
      - rv64_execute.sv
      - rv64_irq_sequencer.sv
      - rv64_core.sv

  # Verification only
  - target: test
    files:
      - rv64_core_props.sv
      - tb_rv64_core.sv

// ==== rv64_core.f ====
+incdir+.
rv64_core_pkg.sv
rv64_frontend.sv
rv64_regfile.sv
rv64_execute.sv
rv64_irq_sequencer.sv
rv64_core.sv
rv64_core_props.sv
tb_rv64_core.sv

// ==== rv64_core.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_core
    import rv64_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,            // Active low, async
    input  logic [31:0]          instruction,
    output logic [31:0]          pc,
    output rv64_instr_u          ir,
    output logic                 heartbeat,
    input  logic [3:0]           interrupt_vector,
    output logic                 interrupt_done,
    output logic [`RV64_XLEN-1:0] bus_address,
    output logic [`RV64_XLEN-1:0] bus_write_data,
    output logic                 bus_write_enable,
    output logic                 bus_read_enable,
    input  logic [`RV64_XLEN-1:0] bus_read_data,
    input  logic [4:0]           dbg_addr,         // Register to peek at
    output logic [`RV64_XLEN-1:0] dbg_data
);

    logic                  ir_valid;
    logic                  redirect;
    logic [31:0]           redirect_pc;
    logic                  busy;
    logic [4:0]            rs1_addr;
    logic [`RV64_XLEN-1:0] rs1_data;
    logic                  wr_en;
    logic [4:0]            wr_addr;
    logic [`RV64_XLEN-1:0] wr_data;

    rv64_frontend u_frontend (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .ir          (ir),
        .ir_valid    (ir_valid),
        .heartbeat   (heartbeat)
    );

    rv64_execute u_execute (
        .ir       (ir),
        .ir_valid (ir_valid),
        .busy     (busy),
        .rs1_data (rs1_data),
        .rs1_addr (rs1_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rv64_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_addr (rs1_addr),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .dbg_data (dbg_data)
    );

    // Sole bus master
    rv64_irq_sequencer u_irq_sequencer (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .interrupt_done   (interrupt_done),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .busy             (busy)
    );

endmodule

// ==== rv64_core_defs.svh ====
`ifndef RV64_CORE_DEFS_SVH
`define RV64_CORE_DEFS_SVH

// Datapath sizing
`define RV64_XLEN      64                      // Integer register width
`define RV64_NREGS     32                      // x0..x31

// Memory map of the two bus devices
`define RV64_KEY_BASE  64'h0000_0000_8000_0010 // Keyboard data port
`define RV64_ART_BASE  64'h0000_0000_8000_0000 // Display character port

// Where the program counter lands after a key interrupt
`define RV64_ISR_BASE  32'h0000_0000

// Vector value presented by the key device
`define RV64_IRQ_KEY   4'd1

// ADDI within the OP-IMM group
`define RV64_F3_ADDI   3'b000

// Sequencer states
`define RV64_SEQ_IDLE  2'd0                    // Armed, waiting for the key vector
`define RV64_SEQ_READ  2'd1                    // S1, key read on the bus
`define RV64_SEQ_WRITE 2'd2                    // S2, display write and redirect
`define RV64_SEQ_WAIT  2'd3                    // S3 onward, until the vector drops

`endif

// ==== rv64_core_pkg.sv ====
`include "rv64_core_defs.svh"

package rv64_core_pkg;

    // Only the two opcodes this slice retires
    typedef enum logic [6:0] {
        OP_LUI = 7'b0110111,
        OP_IMM = 7'b0010011
    } rv64_opcode_e;

    // U-type layout, used by LUI
    typedef struct packed {
        logic [19:0] imm20;    // Upper immediate, bits 31:12
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv64_u_view_t;

    // I-type layout, used by ADDI
    typedef struct packed {
        logic [11:0] imm12;    // Signed immediate
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv64_i_view_t;

    // Same 32 bits decoded either way
    // rd and opcode sit at the same place in both views
    typedef union packed {
        rv64_u_view_t u_view;
        rv64_i_view_t i_view;
    } rv64_instr_u;

endpackage

// ==== rv64_core_props.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_core_props (
    input logic        clk,
    input logic        reset,
    input logic        bus_read_enable,
    input logic        bus_write_enable,
    input logic        interrupt_done,
    input logic [31:0] pc
);

    // One master, one transfer per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable))
        else $error("bus read and write enables high in the same cycle");

    // Done marks the display write and nothing else
    a_done_is_write: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done == bus_write_enable)
        else $error("interrupt_done and bus_write_enable disagree");

    a_redirect: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |=> (pc == `RV64_ISR_BASE))
        else $error("pc did not reach the ISR base after interrupt_done");

    // Quiet bus while held in reset
    a_reset_quiet: assert property (@(posedge clk)
        !reset |-> !(bus_read_enable || bus_write_enable || interrupt_done))
        else $error("bus strobe or interrupt_done active during reset");

endmodule

bind rv64_core rv64_core_props u_rv64_core_props (
    .clk              (clk),
    .reset            (reset),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .interrupt_done   (interrupt_done),
    .pc               (pc)
);

// ==== rv64_execute.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_execute
    import rv64_core_pkg::*;
(
    input  rv64_instr_u          ir,        // Latched instruction word
    input  logic                 ir_valid,  // Low in the bubble slot
    input  logic                 busy,      // Interrupt service in progress
    input  logic [`RV64_XLEN-1:0] rs1_data,
    output logic [4:0]           rs1_addr,
    output logic                 wr_en,
    output logic [4:0]           wr_addr,
    output logic [`RV64_XLEN-1:0] wr_data
);

    logic                  retire;    // Slot may write back
    logic [`RV64_XLEN-1:0] imm_u;     // LUI result
    logic [`RV64_XLEN-1:0] imm_i;     // Sign-extended ADDI immediate

    // Service cycles and the bubble both retire nothing
    assign retire = ir_valid && !busy;

    // U view puts imm20 into bits 31:12 with the sign filled above
    assign imm_u = {{(`RV64_XLEN-32){ir.u_view.imm20[19]}}, ir.u_view.imm20, 12'h000};

    // I view sign-fills the 12-bit immediate to XLEN
    assign imm_i = {{(`RV64_XLEN-12){ir.i_view.imm12[11]}}, ir.i_view.imm12};

    // rs1 always comes out of the I view
    // For LUI the value read is simply not used
    assign rs1_addr = ir.i_view.rs1;
    assign wr_addr  = ir.u_view.rd;   // Same bits in both views

    always_comb begin
        wr_en   = 1'b0;
        wr_data = '0;
        if (retire) begin
            case (ir.u_view.opcode)
                OP_LUI: begin
                    wr_en   = 1'b1;
                    wr_data = imm_u;
                end
                OP_IMM: begin
                    // Other funct3 values than ADDI fall through as no-ops
                    if (ir.i_view.funct3 == `RV64_F3_ADDI) begin
                        wr_en   = 1'b1;
                        wr_data = rs1_data + imm_i;  // Wraps at XLEN
                    end
                end
                default: begin
                    wr_en = 1'b0;  // Unsupported opcode
                end
            endcase
        end
    end

endmodule

// ==== rv64_frontend.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_frontend
    import rv64_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,        // Active low, async
    input  logic [31:0] instruction,  // Fetched word, arrives on a port
    input  logic        redirect,     // One-cycle pulse from the sequencer
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc,
    output rv64_instr_u ir,
    output logic        ir_valid,     // Low for the bubbled slot
    output logic        heartbeat
);

    // Fetch never stalls, so ir and heartbeat move every cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= '0;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;  // Latch the word on the port
            heartbeat <= ~heartbeat;   // Toggles once per clock
        end
    end

    // PC and the bubble flag
    // The word latched at the redirect edge was fetched from the old
    // stream, so it is marked invalid and execute skips it
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc       <= 32'h0000_0000;
            ir_valid <= 1'b0;          // Nothing fetched yet
        end else if (redirect) begin
            pc       <= redirect_pc;   // Jump to the ISR
            ir_valid <= 1'b0;          // Bubble the stale word
        end else begin
            pc       <= pc + 32'd4;    // Sequential fetch
            ir_valid <= 1'b1;
        end
    end

endmodule

// ==== rv64_irq_sequencer.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_irq_sequencer (
    input  logic                 clk,
    input  logic                 reset,            // Active low, async
    input  logic [3:0]           interrupt_vector,
    input  logic [`RV64_XLEN-1:0] bus_read_data,
    output logic [`RV64_XLEN-1:0] bus_address,
    output logic [`RV64_XLEN-1:0] bus_write_data,
    output logic                 bus_write_enable,
    output logic                 bus_read_enable,
    output logic                 interrupt_done,
    output logic                 redirect,         // To the front end
    output logic [31:0]          redirect_pc,
    output logic                 busy              // Holds off execute
);

    logic [1:0]            state;
    logic                  armed;     // Set once the vector has been released
    logic                  key_hit;
    logic [`RV64_XLEN-1:0] key_data;  // Byte read from the key port

    assign key_hit = (interrupt_vector == `RV64_IRQ_KEY);

    // Arming
    // Cleared as the service starts, set again only when the vector goes away
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            armed <= 1'b1;
        end else if (!key_hit) begin
            armed <= 1'b1;
        end else if (state == `RV64_SEQ_IDLE) begin
            armed <= 1'b0;                 // Taking it now
        end
    end

    // Service FSM with one state per S-cycle plus idle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= `RV64_SEQ_IDLE;
        end else begin
            case (state)
                `RV64_SEQ_IDLE:  if (key_hit && armed) state <= `RV64_SEQ_READ;
                `RV64_SEQ_READ:  state <= `RV64_SEQ_WRITE;  // Bus never stalls
                `RV64_SEQ_WRITE: state <= `RV64_SEQ_WAIT;
                `RV64_SEQ_WAIT:  if (armed) state <= `RV64_SEQ_IDLE;
                default:         state <= `RV64_SEQ_IDLE;
            endcase
        end
    end

    // Key data sampled at the end of S1
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_data <= '0;
        end else if (state == `RV64_SEQ_READ) begin
            key_data <= bus_read_data;
        end
    end

    // Strobes decode straight off the state register
    assign bus_read_enable  = (state == `RV64_SEQ_READ);   // S1
    assign bus_write_enable = (state == `RV64_SEQ_WRITE);  // S2
    assign interrupt_done   = (state == `RV64_SEQ_WRITE);  // Same cycle as the write
    assign redirect         = (state == `RV64_SEQ_WRITE);  // PC loads at the S2 edge

    // Key port by default, display port only for the write
    assign bus_address    = (state == `RV64_SEQ_WRITE) ? `RV64_ART_BASE : `RV64_KEY_BASE;
    assign bus_write_data = key_data;   // Echo the key byte

    assign redirect_pc = `RV64_ISR_BASE;
    assign busy        = (state == `RV64_SEQ_READ) || (state == `RV64_SEQ_WRITE);

endmodule

// ==== rv64_regfile.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module rv64_regfile (
    input  logic                 clk,
    input  logic                 reset,     // Active low, async
    input  logic                 wr_en,
    input  logic [4:0]           wr_addr,
    input  logic [`RV64_XLEN-1:0] wr_data,
    input  logic [4:0]           rs1_addr,  // Execute read port
    input  logic [4:0]           dbg_addr,  // Debug read port
    output logic [`RV64_XLEN-1:0] rs1_data,
    output logic [`RV64_XLEN-1:0] dbg_data
);

    logic [`RV64_XLEN-1:0] regs [`RV64_NREGS];

    // Whole array clears on reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RV64_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;  // x0 writes dropped here
        end
    end

    // Both reads combinational
    // x0 stays zero since it is cleared at reset and never written
    assign rs1_data = regs[rs1_addr];
    assign dbg_data = regs[dbg_addr];  // Shows a write one edge after it

endmodule

// ==== tb_rv64_core.sv ====
`timescale 1ns/1ps
`include "rv64_core_defs.svh"

module tb_rv64_core
    import rv64_core_pkg::*;
();

    localparam int TIMEOUT   = 10;   // Cycles allowed for any strobe to show up
    localparam int N_ENTRIES = 8;

    logic                  clk;
    logic                  reset;
    logic [31:0]           instruction;
    logic [31:0]           pc;
    rv64_instr_u           ir;
    logic                  heartbeat;
    logic [3:0]            interrupt_vector;
    logic                  interrupt_done;
    logic [`RV64_XLEN-1:0] bus_address;
    logic [`RV64_XLEN-1:0] bus_write_data;
    logic                  bus_write_enable;
    logic                  bus_read_enable;
    logic [`RV64_XLEN-1:0] bus_read_data;
    logic [4:0]            dbg_addr;
    logic [`RV64_XLEN-1:0] dbg_data;

    // Stimulus table filled at run time from random immediates
    string       tbl_name   [N_ENTRIES];
    logic [31:0] tbl_instr  [N_ENTRIES];
    logic [4:0]  tbl_rd     [N_ENTRIES];
    logic [63:0] tbl_expect [N_ENTRIES];
    logic [63:0] model      [32];       // Expected register contents
    int          n_entries;

    int          errors      = 0;
    int          checks      = 0;
    int          done_pulses = 0;
    logic [15:0] lfsr_state  = 16'd47563;
    logic [63:0] value;

    rv64_core u_rv64_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .dbg_addr         (dbg_addr),
        .dbg_data         (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // Counts interrupt_done cycles at the falling edge
    always @(negedge clk) begin
        if (interrupt_done === 1'b1) begin
            done_pulses++;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11, stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Low `bits` of v treated as signed, widened to 64
    function automatic logic [63:0] sign_extend(input logic [63:0] v, input int bits);
        logic signed [63:0] s;
        s = v << (64 - bits);
        return s >>> (64 - bits);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;                      // Inputs change here, outputs settled
    endtask

    // Debug port is combinational, so a short settle is enough
    task automatic read_reg(input logic [4:0] r, output logic [63:0] v);
        tick();
        dbg_addr = r;
        #0.5;
        v = dbg_data;
    endtask

    task automatic add_lui(input string name, input logic [4:0] rd, input logic [19:0] imm20);
        logic [63:0] result;
        result = sign_extend({32'h0, imm20, 12'h000}, 32);  // Upper immediate
        if (rd != 5'd0) begin
            model[rd] = result;
        end
        tbl_name[n_entries]   = name;
        tbl_instr[n_entries]  = {imm20, rd, OP_LUI};
        tbl_rd[n_entries]     = rd;
        tbl_expect[n_entries] = model[rd];
        n_entries++;
    endtask

    task automatic add_addi(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm12);
        logic [63:0] result;
        result = model[rs1] + sign_extend({52'h0, imm12}, 12);
        if (rd != 5'd0) begin
            model[rd] = result;
        end
        tbl_name[n_entries]   = name;
        tbl_instr[n_entries]  = {imm12, rs1, 3'b000, rd, OP_IMM};
        tbl_rd[n_entries]     = rd;
        tbl_expect[n_entries] = model[rd];
        n_entries++;
    endtask

    task automatic build_table();
        logic [19:0] imm20;
        logic [11:0] imm12;
        n_entries = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        imm20 = 20'(take_bits(20));
        add_lui("lui random", 5'd5, imm20);
        imm12 = 12'(take_bits(12));
        add_addi("addi positive", 5'd6, 5'd5, {1'b0, imm12[10:0]});
        imm12 = 12'(take_bits(12));
        add_addi("addi negative", 5'd7, 5'd5, {1'b1, imm12[10:0]});
        imm20 = 20'(take_bits(20));
        add_lui("lui sign bit", 5'd9, {1'b1, imm20[18:0]});   // Forces upper 32 to ones
        imm12 = 12'(take_bits(12));
        add_addi("addi neg on neg", 5'd10, 5'd9, {1'b1, imm12[10:0]});
        imm20 = 20'(take_bits(20));
        add_lui("lui to x0", 5'd0, imm20);
        imm12 = 12'(take_bits(12));
        add_addi("addi to x0", 5'd0, 5'd5, imm12);
        imm12 = 12'(take_bits(12));
        add_addi("addi from x0", 5'd11, 5'd0, imm12);       // x0 reads as zero
    endtask

    // Waits for one bus strobe, expected right after the next edge
    task automatic wait_strobe(input bit write, input string what, output bit seen);
        int waited;
        waited = 0;
        tick();
        while (((write ? bus_write_enable : bus_read_enable) !== 1'b1) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        seen = ((write ? bus_write_enable : bus_read_enable) === 1'b1);
        if (!seen) begin
            errors++;
            $display("ERROR: %s timed out waiting for the bus strobe", what);
        end else begin
            check({what, " latency"}, 0, waited);
        end
    endtask

    // Key interrupt with the testbench as bus slave
    task automatic run_key_irq(input string name);
        logic [7:0]  key;
        logic [19:0] junk;
        logic [63:0] v;
        bit          seen;
        int          extra;
        key = 8'(take_bits(8));
        tick();
        interrupt_vector = `RV64_IRQ_KEY;
        junk = 20'(take_bits(20));
        instruction = {junk, 5'd5, OP_LUI};    // In ir during S1
        wait_strobe(1'b0, {name, " key read"}, seen);
        if (!seen) begin
            interrupt_vector = '0;
            return;
        end
        check({name, " read address"}, `RV64_KEY_BASE, bus_address);
        bus_read_data = {56'h0, key};          // Sampled at the end of S1
        junk = 20'(take_bits(20));
        instruction = {junk, 5'd6, OP_LUI};    // In ir during S2
        wait_strobe(1'b1, {name, " display write"}, seen);
        if (!seen) begin
            interrupt_vector = '0;
            return;
        end
        bus_read_data = '0;                    // Write data must come from the capture
        #0.5;
        check({name, " write address"}, `RV64_ART_BASE, bus_address);
        check({name, " write data"}, {56'h0, key}, bus_write_data);
        check({name, " done with write"}, 1, interrupt_done);
        check({name, " no read in S2"}, 0, bus_read_enable);
        junk = 20'(take_bits(20));
        instruction = {junk, 5'd7, OP_LUI};    // Lands in the bubble
        tick();
        check({name, " pc at isr"}, `RV64_ISR_BASE, pc);
        instruction = '0;
        extra = 0;
        repeat (6) begin                       // Vector still held
            tick();
            if (bus_read_enable || bus_write_enable || interrupt_done) begin
                extra++;
            end
        end
        check({name, " no retrigger"}, 0, extra);
        for (int r = 5; r < 8; r++) begin
            read_reg(5'(r), v);
            check({name, " reg unchanged"}, model[r], v);
        end
        interrupt_vector = '0;                 // Release re-arms
        repeat (3) tick();
    endtask

    initial begin
        reset            = 1'b0;
        instruction      = '0;               // Opcode 0 retires as a no-op
        interrupt_vector = '0;
        bus_read_data    = '0;
        dbg_addr         = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b1;

        check("reset pc", 0, pc);
        check("reset ir", 0, ir);
        check("reset heartbeat", 0, heartbeat);
        check("reset read enable", 0, bus_read_enable);
        check("reset write enable", 0, bus_write_enable);
        check("reset interrupt done", 0, interrupt_done);
        tick();
        check("pc step", 4, pc);
        check("heartbeat toggle", 1, heartbeat);
        for (int r = 0; r < 32; r += 5) begin
            read_reg(5'(r), value);
            check("reset register", 0, value);
        end

        build_table();
        for (int i = 0; i < n_entries; i++) begin
            tick();
            instruction = tbl_instr[i];
            tick();                            // Enters ir
            check({tbl_name[i], " ir"}, tbl_instr[i], ir);
            instruction = '0;
            read_reg(tbl_rd[i], value);        // Written at this edge
            check(tbl_name[i], tbl_expect[i], value);
        end

        run_key_irq("key irq first");
        run_key_irq("key irq second");
        check("done pulse count", 2, done_pulses);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
